//--- hw/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// --------------------------------------------------
// Serial line timing
// --------------------------------------------------

// Clock cycles per bit
// Kept small so simulation frames stay short
`define UART_BAUD_DIV 16

// --------------------------------------------------
// Frame layout
// --------------------------------------------------

// Start bit, eight data bits, stop bit (8N1)
`define UART_FRAME_BITS 10

`endif

//--- hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // Data byte on every client, arbiter and transmitter port
  typedef logic [7:0] byte_t;

  // --------------------------------------------------
  // Transmitter FSM
  // --------------------------------------------------
  typedef enum logic [1:0] {
    // Line high, waiting for req
    TX_IDLE = 2'd0,
    // Capture the byte, restart the bit timer
    TX_LOAD = 2'd1,
    // Frame going out on the line
    TX_SEND = 2'd2,
    // Ack held until req drops
    TX_ACK  = 2'd3
  } tx_state_e;

  // --------------------------------------------------
  // Arbiter FSM
  // --------------------------------------------------
  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,  // pick a client
    ARB_BUSY    = 2'd1,  // granted request forwarded
    ARB_RELEASE = 2'd2   // wait for transmitter ack to drop
  } arb_state_e;

endpackage

`default_nettype wire

//--- hw/baud_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module baud_gen #(
  parameter int BAUD_DIV = `UART_BAUD_DIV
) (
  input  wire  clk,
  input  wire  rstn,
  input  logic restart,
  output logic tick
);

  // Counter width, at least one bit even for BAUD_DIV of 1
  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(BAUD_DIV - 1);

  // Cycles left in the current bit period
  logic [CNT_W-1:0] cnt;

  // --------------------------------------------------
  // Down counter
  // --------------------------------------------------
  // Restart realigns the bit grid to the frame start
  always_ff @(posedge clk) begin
    if (!rstn || restart) begin
      cnt <= RELOAD;
    end else if (cnt == '0) begin
      // Wrap, start the next bit period
      cnt <= RELOAD;
    end else begin
      cnt <= cnt - CNT_W'(1);
    end
  end

  // One pulse per bit period, at the wrap
  assign tick = (cnt == '0);

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Tick must stay a single-cycle pulse for any divisor above one
  a_tick_single: assert property (
    @(posedge clk) disable iff (!rstn)
    (BAUD_DIV > 1) && tick |=> !tick
  );

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx #(
  parameter int BAUD_DIV = `UART_BAUD_DIV
) (
  input  wire            clk,
  input  wire            rstn,
  input  logic           req,
  input  uart_pkg::byte_t data,
  output logic           ack,
  output logic           tx
);

  import uart_pkg::*;

  // Bit counter wide enough to hold the full frame length
  localparam int CNT_W = $clog2(`UART_FRAME_BITS + 1);

  tx_state_e state;

  // Data plus start bit, LSB goes out first
  logic [8:0] shifter;

  // Bits still to send in this frame
  logic [CNT_W-1:0] bit_cnt;

  // Bit timer handshake
  logic restart;
  logic tick;

  // --------------------------------------------------
  // Bit timer
  // --------------------------------------------------
  baud_gen #(
    .BAUD_DIV (BAUD_DIV)
  ) u_baud (
    .clk     (clk),
    .rstn    (rstn),
    .restart (restart),
    .tick    (tick)
  );

  // Timer restarts while the byte is captured
  assign restart = (state == TX_LOAD);

  // --------------------------------------------------
  // Shifter and bit counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      // All ones keeps the line idle
      shifter <= '1;
      bit_cnt <= '0;
    end else if (state == TX_LOAD) begin
      // Start bit in the LSB, so it leaves first
      shifter <= {data, 1'b0};
      bit_cnt <= CNT_W'(`UART_FRAME_BITS);
    end else if (state == TX_SEND && tick) begin
      // Ones fill from the top and form the stop bit
      shifter <= {1'b1, shifter[8:1]};
      bit_cnt <= bit_cnt - CNT_W'(1);
    end
  end

  // Line follows the shifter LSB directly
  assign tx = shifter[0];

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= TX_IDLE;
    end else begin
      case (state)
        TX_IDLE: begin
          if (req) begin
            state <= TX_LOAD;
          end
        end
        TX_LOAD: begin
          // Start bit shows on the line next cycle
          state <= TX_SEND;
        end
        TX_SEND: begin
          // Last tick closes the stop bit
          if (tick && bit_cnt == CNT_W'(1)) begin
            state <= TX_ACK;
          end
        end
        TX_ACK: begin
          // Four-phase return to zero
          if (!req) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  // Ack is high for as long as the FSM waits for req to drop
  assign ack = (state == TX_ACK);

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Idle line is always high
  a_idle_high: assert property (
    @(posedge clk) disable iff (!rstn)
    (state == TX_IDLE) |-> tx
  );

  // Requester keeps data stable until the frame is acknowledged
  a_data_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    (req && !ack) |=> (ack || $stable(data))
  );

endmodule

`default_nettype wire

//--- hw/tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter (
  input  wire             clk,
  input  wire             rstn,
  // Client 0
  input  logic            c0_req,
  input  uart_pkg::byte_t c0_data,
  output logic            c0_ack,
  // Client 1
  input  logic            c1_req,
  input  uart_pkg::byte_t c1_data,
  output logic            c1_ack,
  // Transmitter side
  output logic            tx_req,
  output uart_pkg::byte_t tx_data,
  input  logic            tx_ack
);

  import uart_pkg::*;

  arb_state_e state;

  // Client granted most recently, also the current grant
  logic last_served;

  // Client chosen in idle
  logic pick;

  // Request line of the granted client
  logic gnt_req;

  // --------------------------------------------------
  // Round-robin choice
  // --------------------------------------------------
  always_comb begin
    if (c0_req && c1_req) begin
      // Both waiting, serve the other one this time
      pick = ~last_served;
    end else begin
      // Only one (or none) waiting
      pick = c1_req;
    end
  end

  assign gnt_req = last_served ? c1_req : c0_req;

  // --------------------------------------------------
  // FSM and forwarded request
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= ARB_IDLE;
      // Client 0 wins the first tie
      last_served <= 1'b1;
      tx_req      <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (c0_req || c1_req) begin
            last_served <= pick;
            tx_req      <= 1'b1;
            state       <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          // Client dropped req after seeing ack
          if (!gnt_req) begin
            tx_req <= 1'b0;
            state  <= ARB_RELEASE;
          end
        end
        ARB_RELEASE: begin
          // Grant held until the transmitter ack is gone
          if (!tx_ack) begin
            state <= ARB_IDLE;
          end
        end
        default: begin
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  // Data captured with the grant, held through the frame
  always_ff @(posedge clk) begin
    if (state == ARB_IDLE && (c0_req || c1_req)) begin
      tx_data <= pick ? c1_data : c0_data;
    end
  end

  // --------------------------------------------------
  // Ack routing
  // --------------------------------------------------
  // One register behind tx_ack, granted client only
  always_ff @(posedge clk) begin
    if (!rstn) begin
      c0_ack <= 1'b0;
      c1_ack <= 1'b0;
    end else begin
      c0_ack <= tx_ack && !last_served;
      c1_ack <= tx_ack && last_served;
    end
  end

  // Only one client can own the transmitter
  a_one_ack: assert property (
    @(posedge clk) disable iff (!rstn)
    !(c0_ack && c1_ack)
  );

endmodule

`default_nettype wire

//--- hw/uart_tx_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx_top #(
  parameter int BAUD_DIV = `UART_BAUD_DIV
) (
  input  wire             clk,
  input  wire             rstn,
  // Client 0 handshake
  input  logic            c0_req,
  input  uart_pkg::byte_t c0_data,
  output logic            c0_ack,
  // Client 1 handshake
  input  logic            c1_req,
  input  uart_pkg::byte_t c1_data,
  output logic            c1_ack,
  // Serial line
  output logic            tx
);

  import uart_pkg::*;

  // --------------------------------------------------
  // Arbiter to transmitter link
  // --------------------------------------------------
  logic  tx_req;
  byte_t tx_data;
  logic  tx_ack;

  // Two clients share one transmitter
  tx_arbiter u_arb (
    .clk     (clk),
    .rstn    (rstn),
    .c0_req  (c0_req),
    .c0_data (c0_data),
    .c0_ack  (c0_ack),
    .c1_req  (c1_req),
    .c1_data (c1_data),
    .c1_ack  (c1_ack),
    .tx_req  (tx_req),
    .tx_data (tx_data),
    .tx_ack  (tx_ack)
  );

  // --------------------------------------------------
  // 8N1 transmitter with its own bit timer
  // --------------------------------------------------
  uart_tx #(
    .BAUD_DIV (BAUD_DIV)
  ) u_tx (
    .clk  (clk),
    .rstn (rstn),
    .req  (tx_req),
    .data (tx_data),
    .ack  (tx_ack),
    .tx   (tx)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  // Half of the 20 ns period
  localparam time HALF_PERIOD = 10ns;

  // Free running clock
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Reset low for the first three rising edges
  initial begin
    rstn <= 1'b0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_uart_tx_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_consts.svh"

module tb_uart_tx_top;

  import uart_pkg::*;

  localparam int DIV         = `UART_BAUD_DIV;
  localparam int FRAME       = `UART_FRAME_BITS;
  // Wait limits in clock cycles
  localparam int HS_LIMIT    = 2000;
  localparam int IDLE_LIMIT  = 5000;
  localparam int RESET_LIMIT = 50;

  logic  clk;
  logic  rstn;
  logic  c0_req;
  byte_t c0_data;
  logic  c0_ack;
  logic  c1_req;
  byte_t c1_data;
  logic  c1_ack;
  logic  tx;

  // Bytes handed to each client port in submission order
  byte_t sent0[$];
  byte_t sent1[$];
  // Client of every ack in ack order
  bit    ack_log[$];
  // Decoded bytes waiting for their ack
  byte_t rx_q[$];

  bit tb_done = 1'b0;

  tb_clk_gen u_clk_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  uart_tx_top #(
    .BAUD_DIV (DIV)
  ) u_dut (
    .clk     (clk),
    .rstn    (rstn),
    .c0_req  (c0_req),
    .c0_data (c0_data),
    .c0_ack  (c0_ack),
    .c1_req  (c1_req),
    .c1_data (c1_data),
    .c1_ack  (c1_ack),
    .tx      (tx)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic wait_negedges(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rstn !== 1'b1) begin
      @(negedge clk);
      n++;
      assert (n < RESET_LIMIT) else stop_on_error("reset was never released");
    end
  endtask

  function automatic logic ack_of(input bit client);
    return client ? c1_ack : c0_ack;
  endfunction

  task automatic drive_client(input bit client, input logic req, input byte_t d);
    if (client) begin
      c1_req  <= req;
      c1_data <= d;
    end else begin
      c0_req  <= req;
      c0_data <= d;
    end
  endtask

  // Acks of the same client logged before entry idx
  function automatic int prior_acks(input int idx);
    int k;
    int i;
    k = 0;
    for (i = 0; i < idx; i++) begin
      if (ack_log[i] == ack_log[idx]) begin
        k++;
      end
    end
    return k;
  endfunction

  // Reference model for ack entry idx
  // Each client is served in its own submission order
  function automatic byte_t expected_byte(input int idx);
    int k;
    k = prior_acks(idx);
    if (ack_log[idx]) begin
      return sent1[k];
    end
    return sent0[k];
  endfunction

  // --------------------------------------------------
  // Four-phase client stimulus
  // --------------------------------------------------
  task automatic send_byte(input bit client, input byte_t d);
    int n;
    // No new req until the last ack is gone
    n = 0;
    do begin
      @(posedge clk);
      n++;
      assert (n < HS_LIMIT) else stop_on_error("timeout waiting for ack low before req");
    end while (ack_of(client));
    drive_client(client, 1'b1, d);
    if (client) begin
      sent1.push_back(d);
    end else begin
      sent0.push_back(d);
    end
    // Data held until ack rises
    n = 0;
    do begin
      @(posedge clk);
      n++;
      assert (n < HS_LIMIT) else stop_on_error("timeout waiting for ack to rise");
    end while (!ack_of(client));
    // Byte already latched so the data lines are free again
    drive_client(client, 1'b0, ~d);
    n = 0;
    do begin
      @(posedge clk);
      n++;
      assert (n < HS_LIMIT) else stop_on_error("timeout waiting for ack to fall");
    end while (ack_of(client));
  endtask

  task automatic run_client(input bit client, input int count, input int max_gap);
    int i;
    for (i = 0; i < count; i++) begin
      repeat ($urandom_range(max_gap, 0)) @(posedge clk);
      send_byte(client, 8'($urandom));
    end
  endtask

  // --------------------------------------------------
  // Line decoder sampling at negedge
  // --------------------------------------------------
  initial begin : line_decoder
    int idle;
    int pos;
    int b;
    logic s_q1;
    logic s_mid;
    logic [FRAME-1:0] frame;
    idle = 0;
    wait_reset_release();
    while (!tb_done) begin
      @(negedge clk);
      if (tx === 1'b0) begin
        // Start edge seen half a cycle into the start bit
        pos = 1;
        frame = '0;
        for (b = 0; b < FRAME; b++) begin
          // Quarter, middle and three quarters of each bit
          wait_negedges(b * DIV + DIV / 4 - pos);
          s_q1 = tx;
          wait_negedges(DIV / 4);
          s_mid = tx;
          wait_negedges(DIV / 4);
          assert (s_q1 === s_mid && tx === s_mid)
            else stop_on_error($sformatf("tx bit %0d not stable around its middle", b));
          frame = {s_mid, frame[FRAME-1:1]};
          pos = b * DIV + 3 * DIV / 4;
        end
        assert (frame[0] === 1'b0) else stop_on_error($sformatf(
          "mismatch time=%0t signal=tx start_bit expected=0 got=%b", $time, frame[0]));
        assert (frame[FRAME-1] === 1'b1) else stop_on_error($sformatf(
          "mismatch time=%0t signal=tx stop_bit expected=1 got=%b", $time, frame[FRAME-1]));
        rx_q.push_back(frame[8:1]);
        idle = 0;
      end else begin
        idle++;
        assert (idle < IDLE_LIMIT) else stop_on_error("no frame on the serial line for too long");
      end
    end
  end

  // --------------------------------------------------
  // Compare at each ack rise
  // --------------------------------------------------
  task automatic check_ack(input bit client, input logic req_now);
    int idx;
    byte_t got;
    byte_t exp;
    assert (req_now === 1'b1) else stop_on_error("ack rose while its req was low");
    ack_log.push_back(client);
    idx = ack_log.size() - 1;
    assert (prior_acks(idx) < (client ? sent1.size() : sent0.size()))
      else stop_on_error($sformatf("client %0d acked with no pending byte", client));
    // Frame must be fully on the line including the stop bit
    assert (rx_q.size() > 0)
      else stop_on_error($sformatf("client %0d ack rose before its frame ended", client));
    got = rx_q.pop_front();
    exp = expected_byte(idx);
    assert (got === exp) else stop_on_error($sformatf(
      "mismatch time=%0t signal=tx expected=%02h got=%02h", $time, exp, got));
  endtask

  initial begin : ack_checker
    logic prev0;
    logic prev1;
    prev0 = 1'b0;
    prev1 = 1'b0;
    wait_reset_release();
    while (!tb_done) begin
      @(negedge clk);
      assert (!(c0_ack && c1_ack)) else stop_on_error("c0_ack and c1_ack high together");
      if (c0_ack && !prev0) begin
        check_ack(1'b0, c0_req);
      end
      if (c1_ack && !prev1) begin
        check_ack(1'b1, c1_req);
      end
      // Return to zero only after the client dropped req
      if (!c0_ack && prev0) begin
        assert (!c0_req) else stop_on_error("c0_ack fell while c0_req was high");
      end
      if (!c1_ack && prev1) begin
        assert (!c1_req) else stop_on_error("c1_ack fell while c1_req was high");
      end
      prev0 = c0_ack;
      prev1 = c1_ack;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : stimulus
    int i;
    int start_idx;
    int n0;
    int n1;
    bit first_exp;
    c0_req  <= 1'b0;
    c0_data <= '0;
    c1_req  <= 1'b0;
    c1_data <= '0;
    void'($urandom(32'h5dfbbdd7));
    wait_reset_release();

    // Quiet line after reset
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (tx === 1'b1) else stop_on_error($sformatf(
        "mismatch time=%0t signal=tx expected=1 got=%b", $time, tx));
      assert (c0_ack === 1'b0) else stop_on_error($sformatf(
        "mismatch time=%0t signal=c0_ack expected=0 got=%b", $time, c0_ack));
      assert (c1_ack === 1'b0) else stop_on_error($sformatf(
        "mismatch time=%0t signal=c1_ack expected=0 got=%b", $time, c1_ack));
    end

    // Single frame from client 0
    send_byte(1'b0, 8'ha5);

    // Client 1 alone
    run_client(1'b1, 8, 3);

    // Both clients back to back with alternating grants
    start_idx = ack_log.size();
    // Opening tie goes to the client not served most recently
    first_exp = ~ack_log[start_idx-1];
    fork
      run_client(1'b0, 6, 0);
      run_client(1'b1, 6, 0);
    join
    assert (ack_log.size() - start_idx == 12) else stop_on_error("contention phase lost acks");
    assert (ack_log[start_idx] == first_exp) else stop_on_error($sformatf(
      "mismatch time=%0t signal=first_grant expected=%0d got=%0d",
      $time, first_exp, ack_log[start_idx]));
    for (i = start_idx + 1; i < ack_log.size(); i++) begin
      assert (ack_log[i] != ack_log[i-1]) else stop_on_error("grant did not alternate");
    end

    // Random timing from both clients
    fork
      run_client(1'b0, 10, 40);
      run_client(1'b1, 10, 40);
    join

    // Every byte acked exactly once
    n0 = 0;
    n1 = 0;
    for (i = 0; i < ack_log.size(); i++) begin
      if (ack_log[i]) begin
        n1++;
      end else begin
        n0++;
      end
    end
    assert (n0 == sent0.size() && n1 == sent1.size())
      else stop_on_error("submitted bytes and acks do not match one to one");
    assert (rx_q.size() == 0) else stop_on_error("frame decoded without a matching ack");

    tb_done = 1'b1;
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/uart_pkg.sv
hw/baud_gen.sv
hw/uart_tx.sv
hw/tx_arbiter.sv
hw/uart_tx_top.sv
testbench/tb_clk_gen.sv
testbench/tb_uart_tx_top.sv

//--- Makefile
# Verilator simulation of the shared UART transmitter

VERILATOR ?= verilator
TOP       ?= tb_uart_tx_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
